// ==== Bender.yml ====
package:
  name: fp_adder

sources:
  - source/fp_add_pkg.sv
  - source/fp_unpack_stage.sv
  - source/fp_align_add_stage.sv
  - source/fp_normalize_stage.sv
  - source/fp_adder.sv
  - target: test
    files:
      - verif/fp_adder_asserts.sv
      - verif/fp_adder_tb.sv

// ==== source/fp_add_pkg.sv ====
`default_nettype none

package fp_add_pkg;

	// IEEE single precision layout
	localparam int EXPONENT_WIDTH = 8;
	localparam int SIGNIFICAND_WIDTH = 23;
	localparam int TOTAL_WIDTH = 1 + EXPONENT_WIDTH + SIGNIFICAND_WIDTH;

	// Two guard bits above the hidden bit hold sign and carry
	localparam int EXT_WIDTH = SIGNIFICAND_WIDTH + 3;

	localparam int MAX_ALIGN_SHIFT = 27;
	localparam int ALIGN_SHIFT_WIDTH = 6;
	localparam int OPCODE_WIDTH = 6;

	// Biased exponent field of infinity and NaN
	localparam int EXPONENT_INF = (1 << EXPONENT_WIDTH) - 1;

	typedef logic [TOTAL_WIDTH-1:0] fp_word_t;
	typedef logic [EXPONENT_WIDTH-1:0] exponent_t;
	typedef logic [SIGNIFICAND_WIDTH-1:0] fraction_t;
	typedef logic signed [EXT_WIDTH-1:0] ext_significand_t;
	typedef logic [EXT_WIDTH-2:0] magnitude_t;
	typedef logic [ALIGN_SHIFT_WIDTH-1:0] align_shift_t;
	typedef logic [OPCODE_WIDTH-1:0] opcode_t;

	localparam opcode_t OP_FADD = 6'b100000;
	localparam opcode_t OP_FSUB = 6'b100001;

	localparam fp_word_t NAN_CANONICAL = 32'h7fc0_0000;

	// Stage 1 to stage 2
	typedef struct packed {
		align_shift_t     align_shift;
		ext_significand_t significand1;
		ext_significand_t significand2;
		exponent_t        exponent1;
		exponent_t        exponent2;
		logic             exponent2_larger;
		logic             result_is_inf;
		logic             result_is_nan;
		logic             inf_sign;
		logic             valid;
	} unpacked_t;

	// Stage 2 to stage 3
	typedef struct packed {
		logic       sign;
		magnitude_t magnitude;
		exponent_t  exponent;
		logic       result_is_inf;
		logic       result_is_nan;
		logic       inf_sign;
		logic       valid;
	} sum_t;

endpackage

`default_nettype wire

// ==== source/fp_adder.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_adder (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 valid_i,
	input  fp_add_pkg::opcode_t  opcode_i,
	input  fp_add_pkg::fp_word_t operand1_i,
	input  fp_add_pkg::fp_word_t operand2_i,
	output logic                 valid_o,
	output fp_add_pkg::fp_word_t result_o
);

	import fp_add_pkg::*;

	unpacked_t unpacked_stage;
	sum_t      sum_stage;

	// Unpack, swap and classify
	fp_unpack_stage i_unpack (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.valid_i    (valid_i),
		.opcode_i   (opcode_i),
		.operand1_i (operand1_i),
		.operand2_i (operand2_i),
		.stage_o    (unpacked_stage)
	);

	// Align and add
	fp_align_add_stage i_align_add (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.stage_i (unpacked_stage),
		.stage_o (sum_stage)
	);

	// Normalize and pack
	fp_normalize_stage i_normalize (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.stage_i  (sum_stage),
		.valid_o  (valid_o),
		.result_o (result_o)
	);

endmodule

`default_nettype wire

// ==== source/fp_align_add_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_align_add_stage (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  fp_add_pkg::unpacked_t stage_i,
	output fp_add_pkg::sum_t      stage_o
);

	import fp_add_pkg::*;

	ext_significand_t aligned2;
	ext_significand_t sum;
	ext_significand_t abs_sum;
	logic             sum_negative;
	sum_t             stage_nxt;

	// Arithmetic shift keeps the sign, shifted out bits are lost
	assign aligned2 = $signed(stage_i.significand2) >>> stage_i.align_shift;

	// Two hidden-bit operands cannot overflow 26 bits
	assign sum = stage_i.significand1 + aligned2;
	assign sum_negative = sum[EXT_WIDTH-1];
	assign abs_sum = sum_negative ? -sum : sum;

	always_comb
	begin
		stage_nxt.sign = sum_negative;
		stage_nxt.magnitude = abs_sum[EXT_WIDTH-2:0];
		if (stage_i.exponent2_larger)
			stage_nxt.exponent = stage_i.exponent2;
		else
			stage_nxt.exponent = stage_i.exponent1;
		stage_nxt.result_is_inf = stage_i.result_is_inf;
		stage_nxt.result_is_nan = stage_i.result_is_nan;
		stage_nxt.inf_sign = stage_i.inf_sign;
		stage_nxt.valid = stage_i.valid;
	end

	always_ff @(posedge clk)
	begin
		stage_o <= stage_nxt;
		if (!rst_n_i)
			stage_o.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== source/fp_normalize_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_normalize_stage (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  fp_add_pkg::sum_t     stage_i,
	output logic                 valid_o,
	output fp_add_pkg::fp_word_t result_o
);

	import fp_add_pkg::*;

	logic                           carry;
	logic                           is_zero;
	logic [4:0]                     lead_pos;
	logic [4:0]                     left_shift;
	logic [SIGNIFICAND_WIDTH:0]     normalized;
	logic signed [EXPONENT_WIDTH+1:0] exponent_adj;
	fp_word_t                       result_nxt;

	assign carry = stage_i.magnitude[EXT_WIDTH-2];
	assign is_zero = stage_i.magnitude == '0;

	// Highest set bit below the carry, later hits overwrite earlier ones
	always_comb
	begin
		lead_pos = '0;
		for (int i = 0; i <= SIGNIFICAND_WIDTH; i++)
		begin
			if (stage_i.magnitude[i])
				lead_pos = 5'(i);
		end
	end

	assign left_shift = 5'(SIGNIFICAND_WIDTH) - lead_pos;

	always_comb
	begin
		if (carry)
		begin
			// Truncate the bit that falls off
			normalized = stage_i.magnitude[SIGNIFICAND_WIDTH+1:1];
			exponent_adj = {2'b00, stage_i.exponent} + 10'd1;
		end
		else
		begin
			normalized = stage_i.magnitude[SIGNIFICAND_WIDTH:0] << left_shift;
			exponent_adj = {2'b00, stage_i.exponent} - {5'b00000, left_shift};
		end
	end

	always_comb
	begin
		if (stage_i.result_is_nan)
			result_nxt = NAN_CANONICAL;
		else if (stage_i.result_is_inf)
			result_nxt = {stage_i.inf_sign, exponent_t'(EXPONENT_INF), {SIGNIFICAND_WIDTH{1'b0}}};
		else if (is_zero)
			result_nxt = '0;
		else if (exponent_adj <= 0)
			// Flush to +0, no denormals
			result_nxt = '0;
		else if (exponent_adj >= EXPONENT_INF)
			result_nxt = {stage_i.sign, exponent_t'(EXPONENT_INF), {SIGNIFICAND_WIDTH{1'b0}}};
		else
			result_nxt = {stage_i.sign, exponent_adj[EXPONENT_WIDTH-1:0],
				normalized[SIGNIFICAND_WIDTH-1:0]};
	end

	always_ff @(posedge clk)
	begin
		result_o <= result_nxt;
		if (!rst_n_i)
			valid_o <= 1'b0;
		else
			valid_o <= stage_i.valid;
	end

endmodule

`default_nettype wire

// ==== source/fp_unpack_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_unpack_stage (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  valid_i,
	input  fp_add_pkg::opcode_t   opcode_i,
	input  fp_add_pkg::fp_word_t  operand1_i,
	input  fp_add_pkg::fp_word_t  operand2_i,
	output fp_add_pkg::unpacked_t stage_o
);

	import fp_add_pkg::*;

	logic                    sign1;
	logic                    sign2;
	exponent_t               exponent1;
	exponent_t               exponent2;
	fraction_t               fraction1;
	fraction_t               fraction2;
	logic                    subtract;
	logic                    eff_sign2;
	logic [EXPONENT_WIDTH:0] exponent_difference;
	logic                    exponent2_larger;
	logic [EXPONENT_WIDTH:0] shift_abs;
	align_shift_t            align_shift;
	ext_significand_t        magnitude1;
	ext_significand_t        magnitude2;
	ext_significand_t        twos1;
	ext_significand_t        twos2;
	logic                    is_inf1;
	logic                    is_inf2;
	logic                    is_nan1;
	logic                    is_nan2;
	logic                    result_is_inf;
	logic                    result_is_nan;
	logic                    inf_sign;
	unpacked_t               stage_nxt;

	assign sign1 = operand1_i[TOTAL_WIDTH-1];
	assign exponent1 = operand1_i[SIGNIFICAND_WIDTH +: EXPONENT_WIDTH];
	assign fraction1 = operand1_i[SIGNIFICAND_WIDTH-1:0];
	assign sign2 = operand2_i[TOTAL_WIDTH-1];
	assign exponent2 = operand2_i[SIGNIFICAND_WIDTH +: EXPONENT_WIDTH];
	assign fraction2 = operand2_i[SIGNIFICAND_WIDTH-1:0];

	// Anything but add is treated as subtract
	assign subtract = opcode_i != OP_FADD;
	assign eff_sign2 = sign2 ^ subtract;

	// Borrow out of the 9 bit difference marks the larger exponent
	assign exponent_difference = {1'b0, exponent1} - {1'b0, exponent2};
	assign exponent2_larger = exponent_difference[EXPONENT_WIDTH];
	assign shift_abs = exponent2_larger ? -exponent_difference : exponent_difference;

	// Beyond 27 the smaller operand is only sign bits anyway
	assign align_shift = (shift_abs > MAX_ALIGN_SHIFT) ? align_shift_t'(MAX_ALIGN_SHIFT)
		: align_shift_t'(shift_abs);

	// No hidden bit for a zero exponent
	assign magnitude1 = {2'b00, exponent1 != '0, fraction1};
	assign magnitude2 = {2'b00, exponent2 != '0, fraction2};

	assign twos1 = sign1 ? -magnitude1 : magnitude1;
	assign twos2 = eff_sign2 ? -magnitude2 : magnitude2;

	assign is_inf1 = (exponent1 == exponent_t'(EXPONENT_INF)) && (fraction1 == '0);
	assign is_nan1 = (exponent1 == exponent_t'(EXPONENT_INF)) && (fraction1 != '0);
	assign is_inf2 = (exponent2 == exponent_t'(EXPONENT_INF)) && (fraction2 == '0);
	assign is_nan2 = (exponent2 == exponent_t'(EXPONENT_INF)) && (fraction2 != '0);

	// Infinity outranks NaN, except inf - inf
	always_comb
	begin
		result_is_inf = 1'b0;
		result_is_nan = 1'b0;
		inf_sign = sign1;
		if (is_inf1 || is_inf2)
		begin
			if (is_inf1 && is_inf2 && (sign1 != eff_sign2))
				result_is_nan = 1'b1;
			else
				result_is_inf = 1'b1;
			inf_sign = is_inf1 ? sign1 : eff_sign2;
		end
		else if (is_nan1 || is_nan2)
		begin
			result_is_nan = 1'b1;
		end
	end

	always_comb
	begin
		stage_nxt.align_shift = align_shift;
		if (exponent2_larger)
		begin
			stage_nxt.significand1 = twos2;
			stage_nxt.significand2 = twos1;
		end
		else
		begin
			stage_nxt.significand1 = twos1;
			stage_nxt.significand2 = twos2;
		end
		stage_nxt.exponent1 = exponent1;
		stage_nxt.exponent2 = exponent2;
		stage_nxt.exponent2_larger = exponent2_larger;
		stage_nxt.result_is_inf = result_is_inf;
		stage_nxt.result_is_nan = result_is_nan;
		stage_nxt.inf_sign = inf_sign;
		stage_nxt.valid = valid_i;
	end

	always_ff @(posedge clk)
	begin
		stage_o <= stage_nxt;
		if (!rst_n_i)
			stage_o.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
source/fp_add_pkg.sv
source/fp_unpack_stage.sv
source/fp_align_add_stage.sv
source/fp_normalize_stage.sv
source/fp_adder.sv
verif/fp_adder_asserts.sv
verif/fp_adder_tb.sv

// ==== verif/fp_adder_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_adder_asserts (
	input logic                  clk,
	input logic                  rst_n_i,
	input logic                  valid_i,
	input logic                  valid_out_i,
	input fp_add_pkg::unpacked_t stage1_i
);

	// The edge that samples reset clears the output strobe
	valid_low_in_reset: assert property (@(posedge clk) !rst_n_i |=> !valid_out_i)
		else $error("valid_o set while reset is active");

	valid_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
		$past(rst_n_i, 3) |-> valid_out_i == $past(valid_i, 3))
		else $error("valid_o does not follow valid_i by three cycles");

	special_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
		stage1_i.valid |-> !(stage1_i.result_is_inf && stage1_i.result_is_nan))
		else $error("stage 1 flags infinity and NaN together");

endmodule

bind fp_adder fp_adder_asserts i_asserts (
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.valid_i     (valid_i),
	.valid_out_i (valid_o),
	.stage1_i    (unpacked_stage)
);

`default_nettype wire

// ==== verif/fp_adder_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_adder_tb;

	import fp_add_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int RESET_IDLE = 4;
	localparam int RANDOM_OPS = 300;
	localparam int SPECIAL_OPS = 16;
	localparam int ZERO_OPS = 24;
	localparam int RANGE_OPS = 40;
	localparam int GAPPED_CYCLES = 200;
	localparam int NUM_TESTS = 6;
	localparam int TIMEOUT_LIMIT = RESET_CYCLES + RESET_IDLE + RANDOM_OPS + SPECIAL_OPS
		+ ZERO_OPS + RANGE_OPS + GAPPED_CYCLES + 3 * NUM_TESTS + 100;

	logic       clk;
	logic       rst_n_i;
	logic       valid_i;
	opcode_t    opcode_i;
	fp_word_t   operand1_i;
	fp_word_t   operand2_i;
	logic       valid_o;
	fp_word_t   result_o;
	integer     seed;
	fp_word_t   expected_q[$];
	fp_word_t   expected_word;
	logic [2:0] valid_pipe;
	string      test_name;
	int         error_count;
	int         test_errors_start;
	int         failed_tests;
	int         cycle_count;

	fp_adder i_dut (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.valid_i    (valid_i),
		.opcode_i   (opcode_i),
		.operand1_i (operand1_i),
		.operand2_i (operand2_i),
		.valid_o    (valid_o),
		.result_o   (result_o)
	);

	always #20 clk = ~clk;

	// Truncating reference on plain integers
	function automatic fp_word_t expected_result(input opcode_t op, input fp_word_t a,
		input fp_word_t b);
		logic s1, s2, sign;
		logic inf1, inf2, nan1, nan2;
		int e1, e2, v1, v2;
		int shift, exponent, sum, mag;
		s1 = a[31];
		s2 = b[31] ^ (op != OP_FADD);
		e1 = a[30:23];
		e2 = b[30:23];
		inf1 = e1 == 255 && a[22:0] == 0;
		nan1 = e1 == 255 && a[22:0] != 0;
		inf2 = e2 == 255 && b[22:0] == 0;
		nan2 = e2 == 255 && b[22:0] != 0;
		if (inf1 && inf2 && s1 != s2)
			return NAN_CANONICAL;
		if (inf1 || inf2)
			return {inf1 ? s1 : s2, 8'hff, 23'd0};
		if (nan1 || nan2)
			return NAN_CANONICAL;
		v1 = (e1 != 0 ? (1 << 23) : 0) + a[22:0];
		v2 = (e2 != 0 ? (1 << 23) : 0) + b[22:0];
		if (s1)
			v1 = -v1;
		if (s2)
			v2 = -v2;
		exponent = (e2 > e1) ? e2 : e1;
		shift = (e2 > e1) ? e2 - e1 : e1 - e2;
		if (shift > 27)
			shift = 27;
		// Smaller exponent side loses its low bits
		sum = (e2 > e1) ? v2 + (v1 >>> shift) : v1 + (v2 >>> shift);
		sign = sum < 0;
		mag = sign ? -sum : sum;
		if (mag == 0)
			return '0;
		if (mag >= (1 << 24))
		begin
			mag = mag >>> 1;
			exponent++;
		end
		while (mag < (1 << 23))
		begin
			mag = mag << 1;
			exponent--;
		end
		if (exponent <= 0)
			return '0;
		if (exponent >= 255)
			return {sign, 8'hff, 23'd0};
		return {sign, exponent[7:0], mag[22:0]};
	endfunction

	function automatic logic random_bit();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	function automatic fp_word_t random_normal();
		fp_word_t w;
		w = $random(seed);
		w[30:23] = exponent_t'(1 + $unsigned($random(seed)) % 254);
		return w;
	endfunction

	function automatic opcode_t random_opcode();
		int r;
		r = $random(seed);
		// Now and then a code that is neither add nor subtract
		if (r[3:0] == 4'd0)
			return opcode_t'(r[9:4]);
		return r[4] ? OP_FSUB : OP_FADD;
	endfunction

	task automatic compare_word(input string name, input fp_word_t expected,
		input fp_word_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected valid_o %b, actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic drive_cycle(input logic issue, input opcode_t op, input fp_word_t a,
		input fp_word_t b);
		@(posedge clk);
		#2;
		valid_i = issue;
		opcode_i = op;
		operand1_i = a;
		operand2_i = b;
		if (issue)
			expected_q.push_back(expected_result(op, a, b));
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors_start = error_count;
	endtask

	task automatic end_test();
		drive_cycle(1'b0, OP_FADD, '0, '0);
		while (expected_q.size() != 0)
			@(posedge clk);
		@(posedge clk);
		if (error_count == test_errors_start)
			$display("Test %-8s done, no errors", test_name);
		else
		begin
			$display("Test %-8s done, %0d errors", test_name, error_count - test_errors_start);
			failed_tests++;
		end
	endtask

	task automatic run_random_ops();
		fp_word_t a;
		fp_word_t b;
		begin_test("random");
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			a = random_normal();
			b = random_normal();
			// Equal exponents now and then so that sums cancel
			if (random_bit() && random_bit())
				b[30:23] = a[30:23];
			drive_cycle(1'b1, random_opcode(), a, b);
		end
		end_test();
	endtask

	task automatic run_special_values();
		fp_word_t inf_word;
		fp_word_t inf_flipped;
		fp_word_t nan_word;
		begin_test("specials");
		for (int i = 0; i < SPECIAL_OPS; i++)
		begin
			inf_word = {random_bit(), exponent_t'(EXPONENT_INF), fraction_t'(0)};
			inf_flipped = inf_word ^ 32'h8000_0000;
			nan_word = {random_bit(), exponent_t'(EXPONENT_INF),
				fraction_t'($random(seed)) | fraction_t'(1)};
			case (i % 8)
				0: drive_cycle(1'b1, random_opcode(), inf_word, random_normal());
				1: drive_cycle(1'b1, OP_FSUB, random_normal(), inf_word);
				2: drive_cycle(1'b1, OP_FSUB, inf_word, inf_word);
				3: drive_cycle(1'b1, OP_FADD, inf_word, inf_flipped);
				4: drive_cycle(1'b1, OP_FADD, inf_word, inf_word);
				5: drive_cycle(1'b1, OP_FSUB, inf_word, inf_flipped);
				6: drive_cycle(1'b1, random_opcode(), nan_word, random_normal());
				default: drive_cycle(1'b1, random_opcode(), random_normal(), nan_word);
			endcase
		end
		end_test();
	endtask

	task automatic run_zero_cases();
		fp_word_t x;
		fp_word_t zero_a;
		fp_word_t zero_b;
		begin_test("zeros");
		for (int i = 0; i < ZERO_OPS; i++)
		begin
			x = random_normal();
			zero_a = {random_bit(), 31'd0};
			zero_b = {random_bit(), 31'd0};
			case (i % 3)
				0: drive_cycle(1'b1, OP_FSUB, x, x);
				1: drive_cycle(1'b1, random_opcode(), zero_a, x);
				default: drive_cycle(1'b1, random_opcode(), zero_a, zero_b);
			endcase
		end
		end_test();
	endtask

	task automatic run_range_limits();
		fp_word_t a;
		fp_word_t b;
		begin_test("range");
		for (int i = 0; i < RANGE_OPS; i++)
		begin
			a = random_normal();
			b = random_normal();
			b[31] = a[31];
			if (i % 2 == 0)
			begin
				// Carry out of the top exponent
				a[30:23] = 8'd254;
				b[30:23] = 8'd254;
				drive_cycle(1'b1, OP_FADD, a, b);
			end
			else
			begin
				a[30:23] = exponent_t'(1 + random_bit());
				b = a ^ {26'd0, 6'($random(seed))};
				drive_cycle(1'b1, OP_FSUB, a, b);
			end
		end
		end_test();
	endtask

	task automatic run_gapped_stream();
		begin_test("gapped");
		for (int i = 0; i < GAPPED_CYCLES; i++)
		begin
			if (random_bit())
				drive_cycle(1'b1, random_opcode(), random_normal(), random_normal());
			else
				drive_cycle(1'b0, random_opcode(), $random(seed), $random(seed));
		end
		end_test();
	endtask

	always @(posedge clk)
		valid_pipe <= {valid_pipe[1:0], rst_n_i & valid_i};

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin
		compare_valid(test_name, valid_pipe[2], valid_o);
		if (valid_o === 1'b1)
		begin
			if (expected_q.size() == 0)
			begin
				$display("Unexpected result in %s: valid_o high with nothing outstanding",
					test_name);
				error_count++;
			end
			else
			begin
				expected_word = expected_q.pop_front();
				compare_word(test_name, expected_word, result_o);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_LIMIT)
		begin
			$display("Timeout after %0d cycles, the run did not complete", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		// A strobe during reset must not reach the output
		valid_i = 1'b1;
		opcode_i = OP_FADD;
		operand1_i = '0;
		operand2_i = '0;
		valid_pipe = '0;
		seed = 32'h1796_358b;
		error_count = 0;
		failed_tests = 0;
		cycle_count = 0;
		begin_test("reset");
		repeat (RESET_CYCLES)
			@(posedge clk);
		#2;
		rst_n_i = 1'b1;
		valid_i = 1'b0;
		repeat (RESET_IDLE)
			drive_cycle(1'b0, random_opcode(), $random(seed), $random(seed));
		end_test();
		run_random_ops();
		run_special_values();
		run_zero_cases();
		run_range_limits();
		run_gapped_stream();
		$display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
